/* tests/exu_patterns.txt */
# flush pc imm rs1 rs2 csrs inst csr_wen r_wen mem_wen mem_ren rd funct3
# imm_op alu_op src1_sel src2_sel inv_flag jump_flag branch_flag expected_ex_result (all hex)
0 1000 7ff 5 3 0 7ff28293 0 1 0 0 5 0 0 0 0 0 0 0 0 804
0 1004 abcde800 1000 0 0 80008093 0 1 0 0 1 0 0 0 0 0 0 0 0 800
0 1008 fff12345 0 0 0 123452b7 0 1 0 0 5 0 1 0 2 0 0 0 0 12345000
0 80000000 1 0 0 0 00001297 0 1 0 0 5 0 1 0 1 0 0 0 0 80001000
0 2000 400 0 0 0 0080006f 0 1 0 0 1 0 2 0 1 0 0 1 0 2800
0 2000 ffffe 0 0 0 ffdff0ef 0 1 0 0 1 0 2 0 1 0 0 1 0 1ffc
0 0 0 10 30 0 40628233 0 1 0 0 3 0 0 1 0 1 0 0 0 ffffffe0
0 0 fe3 f 0 0 00329193 0 1 0 0 3 1 3 2 0 0 0 0 0 78
0 0 0 ffffffff 1 0 00b52233 0 1 0 0 4 2 0 3 0 1 0 0 0 1
0 3000 0 ffffffff 1 0 00b55463 0 0 0 0 0 5 0 3 0 1 1 0 1 0
0 0 0 1 ffffffff 0 00b53233 0 1 0 0 4 3 0 4 0 1 0 0 0 1
0 3004 0 ffffffff 1 0 00b57463 0 0 0 0 0 7 0 4 0 1 1 0 1 1
0 0 0 f0f0f0f0 0 ffff0000 30002373 5 1 0 0 6 4 0 5 0 2 0 0 0 0f0ff0f0
0 0 0 80000000 24 0 00b553b3 0 1 0 0 7 5 0 6 0 1 0 0 0 08000000
0 0 0 80000000 4 0 40b553b3 0 1 0 0 7 5 0 7 0 1 0 0 0 f8000000
0 0 0 ff0000 ff00 0 00b56433 0 1 0 0 8 6 0 8 0 1 0 0 0 00ffff00
0 0 0 ffff00ff 0 0f0f0f0f 30053473 a 1 0 0 8 7 0 9 0 2 0 0 0 0f0f000f
0 4000 0 1234 1234 0 00b50463 0 0 0 0 0 0 0 a 0 1 0 0 1 1
0 4004 0 1234 1235 0 00b51463 0 0 0 0 0 1 0 a 0 1 1 0 1 1
0 0 0 dead 0 0 00000013 0 1 0 0 9 0 0 0 3 3 1 0 0 1
1 5000 8 100 0 0 00802083 f 1 1 1 1 2 0 0 0 0 0 1 1 108
0 5004 ffc 200 0 0 ffc12103 0 1 0 1 2 2 0 0 0 0 0 0 0 1fc
2 5008 10 300 55 0 00a32023 3 1 1 0 4 2 0 0 0 0 0 1 1 310
0 500c 10 300 55 0 00532823 0 0 1 0 0 2 0 0 0 0 0 0 0 310
0 0 0 5 6 0 0 0 1 0 0 a 0 0 1 0 3 0 0 0 5
0 0 0 5 6 0 0 0 1 0 0 b 0 0 f 0 1 0 0 0 0
0 0 0 1 21 0 00b51633 0 1 0 0 c 1 0 2 0 1 0 0 0 2

/* project.f */
+incdir+verilog
verilog/exu_pkg.sv
verilog/imm_gen.sv
verilog/alu.sv
verilog/exu.sv
tests/exu_tb.sv

/* Makefile */
TOP = exu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f project.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

/* tests/exu_tb.sv */
`timescale 1ns/1ps

`include "exu_consts.svh"

module exu_tb;

    import exu_pkg::*;

    localparam int WAIT_LIMIT = 20;
    localparam int FIELDS     = 21;

    logic clk, rst_n, inst_clear;
    logic [`EXU_XLEN-1:0] pc, imm, rs1_value, rs2_value, csrs, inst;
    logic [`EXU_CSR_WEN_W-1:0] csr_wen;
    logic r_wen, mem_wen, mem_ren;
    logic [`EXU_REG_AW-1:0] rd;
    logic [`EXU_FUNCT3_W-1:0] funct3;
    imm_op_t imm_op;
    alu_op_t alu_op;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    logic inv_flag, jump_flag, branch_flag;
    logic valid_last, ready_last, ready_next, valid_next;
    logic [`EXU_XLEN-1:0] pc_next, imm_next, rs2_value_next, csrs_next, inst_next, ex_result;
    logic [`EXU_CSR_WEN_W-1:0] csr_wen_next;
    logic r_wen_next, mem_wen_next, mem_ren_next, jump_flag_next, branch_flag_next;
    logic [`EXU_REG_AW-1:0] rd_next;
    logic [`EXU_FUNCT3_W-1:0] funct3_next;

    // Fields of the current vector line.
    logic [31:0] v_flush, v_pc, v_imm, v_rs1, v_rs2, v_csrs, v_inst, v_csr_wen;
    logic [31:0] v_r_wen, v_mem_wen, v_mem_ren, v_rd, v_funct3, v_imm_op, v_alu_op;
    logic [31:0] v_src1, v_src2, v_inv, v_jump, v_branch, v_expect;

    // Expected state of the stage outputs.
    logic [31:0] e_pc, e_imm, e_rs2, e_csrs, e_inst, e_result, e_csr_wen, e_rd, e_funct3;
    logic [31:0] e_r_wen, e_mem_wen, e_mem_ren, e_jump, e_branch;
    logic        have_data;
    logic [31:0] lfsr_state;

    exu exu_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_bit(output logic bit_out);
        lfsr_state = lfsr_next(lfsr_state);
        bit_out = lfsr_state[0];
    endtask

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_outputs(input logic exp_valid);
        check_value("valid_next", 32'(valid_next), 32'(exp_valid));
        check_value("r_wen_next", 32'(r_wen_next), e_r_wen);
        check_value("mem_wen_next", 32'(mem_wen_next), e_mem_wen);
        check_value("mem_ren_next", 32'(mem_ren_next), e_mem_ren);
        check_value("csr_wen_next", 32'(csr_wen_next), e_csr_wen);
        check_value("jump_flag_next", 32'(jump_flag_next), e_jump);
        check_value("branch_flag_next", 32'(branch_flag_next), e_branch);
        check_value("inst_next", inst_next, e_inst);
        // Datapath outputs hold no defined value before the first transfer.
        if (have_data) begin
            check_value("pc_next", pc_next, e_pc);
            check_value("imm_next", imm_next, e_imm);
            check_value("rs2_value_next", rs2_value_next, e_rs2);
            check_value("csrs_next", csrs_next, e_csrs);
            check_value("rd_next", 32'(rd_next), e_rd);
            check_value("funct3_next", 32'(funct3_next), e_funct3);
            check_value("ex_result", ex_result, e_result);
        end
    endtask

    task automatic drive_vector();
        pc          = v_pc;
        imm         = v_imm;
        rs1_value   = v_rs1;
        rs2_value   = v_rs2;
        csrs        = v_csrs;
        inst        = v_inst;
        csr_wen     = v_csr_wen[`EXU_CSR_WEN_W-1:0];
        r_wen       = v_r_wen[0];
        mem_wen     = v_mem_wen[0];
        mem_ren     = v_mem_ren[0];
        rd          = v_rd[`EXU_REG_AW-1:0];
        funct3      = v_funct3[`EXU_FUNCT3_W-1:0];
        imm_op      = imm_op_t'(v_imm_op[`EXU_IMM_OP_W-1:0]);
        alu_op      = alu_op_t'(v_alu_op[`EXU_ALU_OP_W-1:0]);
        src1_sel    = src1_sel_t'(v_src1[`EXU_SRC_SEL_W-1:0]);
        src2_sel    = src2_sel_t'(v_src2[`EXU_SRC_SEL_W-1:0]);
        inv_flag    = v_inv[0];
        jump_flag   = v_jump[0];
        branch_flag = v_branch[0];
    endtask

    task automatic drive_idle();
        valid_last = 1'b0;
        ready_next = 1'b1;
        inst_clear = 1'b0;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        #1;
        while (ready_last !== 1'b1) begin
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Timed out waiting for ready_last before a transfer.");
                stop_run();
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // A stalled cycle offers the next vector while downstream is not ready.
    task automatic idle_cycle(input logic stall);
        if (stall) begin
            drive_vector();
            valid_last = 1'b1;
            ready_next = 1'b0;
            inst_clear = 1'b0;
            #1;
            check_value("ready_last", 32'(ready_last), 32'd0);
        end else begin
            drive_idle();
        end
        @(posedge clk);
        #1;
        check_outputs(1'b0);
    endtask

    task automatic flush_idle();
        drive_idle();
        inst_clear = 1'b1;
        @(posedge clk);
        #1;
        inst_clear = 1'b0;
        e_inst = '0;
        check_outputs(1'b0);
    endtask

    task automatic transfer();
        logic squashed;
        squashed = (v_flush != 0);
        drive_vector();
        valid_last = 1'b1;
        ready_next = 1'b1;
        inst_clear = (v_flush == 1);
        wait_ready();
        @(posedge clk);
        #1;
        drive_idle();
        e_pc      = v_pc;
        e_imm     = v_imm;
        e_rs2     = v_rs2;
        e_csrs    = v_csrs;
        e_rd      = v_rd;
        e_funct3  = v_funct3;
        e_result  = v_expect;
        e_inst    = (v_flush == 1) ? '0 : v_inst;
        e_csr_wen = squashed ? '0 : v_csr_wen;
        e_r_wen   = squashed ? '0 : v_r_wen;
        e_mem_wen = squashed ? '0 : v_mem_wen;
        e_mem_ren = squashed ? '0 : v_mem_ren;
        e_jump    = squashed ? '0 : v_jump;
        e_branch  = squashed ? '0 : v_branch;
        have_data = 1'b1;
        check_outputs(!squashed);
    endtask

    initial begin
        int fd;
        int count;
        int vectors;
        string line;
        logic bit_a, bit_b, stall;
        logic [1:0] idle_count;
        clk = 1'b0;
        rst_n = 1'b0;
        pc = '0;
        imm = '0;
        rs1_value = '0;
        rs2_value = '0;
        csrs = '0;
        inst = '0;
        csr_wen = '0;
        r_wen = 1'b0;
        mem_wen = 1'b0;
        mem_ren = 1'b0;
        rd = '0;
        funct3 = '0;
        imm_op = IMM_I12;
        alu_op = ALU_ADD;
        src1_sel = SRC1_RS1;
        src2_sel = SRC2_IMM;
        inv_flag = 1'b0;
        jump_flag = 1'b0;
        branch_flag = 1'b0;
        drive_idle();
        {e_pc, e_imm, e_rs2, e_csrs, e_inst, e_result, e_csr_wen} = '0;
        {e_rd, e_funct3, e_r_wen, e_mem_wen, e_mem_ren, e_jump, e_branch} = '0;
        have_data = 1'b0;
        lfsr_state = 32'hf2db;
        vectors = 0;

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_outputs(1'b0);

        fd = $fopen("tests/exu_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tests/exu_patterns.txt.");
            stop_run();
        end
        while ($fgets(line, fd) != 0) begin
            // Lines that start with # are comments.
            if (line.len() < 2 || line[0] == 8'h23) begin
                continue;
            end
            count = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                v_flush, v_pc, v_imm, v_rs1, v_rs2, v_csrs, v_inst, v_csr_wen,
                v_r_wen, v_mem_wen, v_mem_ren, v_rd, v_funct3, v_imm_op, v_alu_op,
                v_src1, v_src2, v_inv, v_jump, v_branch, v_expect);
            if (count != FIELDS) begin
                $display("Malformed line in the vector file: %s", line);
                stop_run();
            end
            random_bit(bit_a);
            random_bit(bit_b);
            idle_count = {bit_b, bit_a};
            repeat (idle_count) begin
                random_bit(stall);
                idle_cycle(stall);
            end
            if (v_flush == 2) begin
                flush_idle();
            end
            transfer();
            vectors++;
        end
        $fclose(fd);

        if (vectors > 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "No vectors were run.");
        end
    end

endmodule

/* verilog/exu.sv */
`timescale 1ns/1ps

`include "exu_consts.svh"

module exu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        inst_clear,

    input  logic [`EXU_XLEN-1:0]        pc,
    input  logic [`EXU_XLEN-1:0]        imm,
    input  logic [`EXU_XLEN-1:0]        rs1_value,
    input  logic [`EXU_XLEN-1:0]        rs2_value,
    input  logic [`EXU_XLEN-1:0]        csrs,
    input  logic [`EXU_XLEN-1:0]        inst,
    input  logic [`EXU_CSR_WEN_W-1:0]   csr_wen,
    input  logic                        r_wen,
    input  logic                        mem_wen,
    input  logic                        mem_ren,
    input  logic [`EXU_REG_AW-1:0]      rd,
    input  logic [`EXU_FUNCT3_W-1:0]    funct3,
    input  exu_pkg::imm_op_t            imm_op,
    input  exu_pkg::alu_op_t            alu_op,
    input  exu_pkg::src1_sel_t          src1_sel,
    input  exu_pkg::src2_sel_t          src2_sel,
    input  logic                        inv_flag,
    input  logic                        jump_flag,
    input  logic                        branch_flag,

    input  logic                        valid_last,
    output logic                        ready_last,
    input  logic                        ready_next,
    output logic                        valid_next,

    output logic [`EXU_XLEN-1:0]        pc_next,
    output logic [`EXU_XLEN-1:0]        imm_next,
    output logic [`EXU_XLEN-1:0]        rs2_value_next,
    output logic [`EXU_XLEN-1:0]        csrs_next,
    output logic [`EXU_XLEN-1:0]        inst_next,
    output logic [`EXU_XLEN-1:0]        ex_result,
    output logic [`EXU_CSR_WEN_W-1:0]   csr_wen_next,
    output logic                        r_wen_next,
    output logic                        mem_wen_next,
    output logic                        mem_ren_next,
    output logic [`EXU_REG_AW-1:0]      rd_next,
    output logic [`EXU_FUNCT3_W-1:0]    funct3_next,
    output logic                        jump_flag_next,
    output logic                        branch_flag_next
);

    import exu_pkg::*;

    logic                   take;
    logic                   squash;
    logic                   flush_pend;

    logic [`EXU_XLEN-1:0]   rs1_q;
    imm_op_t                imm_op_q;
    alu_op_t                alu_op_q;
    src1_sel_t              src1_sel_q;
    src2_sel_t              src2_sel_q;
    logic                   inv_flag_q;

    logic [`EXU_XLEN-1:0]   imm_ext;
    logic [`EXU_XLEN-1:0]   op_a;
    logic [`EXU_XLEN-1:0]   op_b;
    logic [`EXU_XLEN-1:0]   alu_result;

    // Downstream only asserts ready when it will consume the next cycle's output.
    assign ready_last = ready_next;
    assign take       = valid_last & ready_last;
    assign squash     = inst_clear | flush_pend;

    // A flush seen while idle is held until it can kill the next arrival.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_pend <= 1'b0;
        end else if (take) begin
            flush_pend <= 1'b0;
        end else if (inst_clear) begin
            flush_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_next <= 1'b0;
        end else begin
            valid_next <= take & ~squash;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_wen_next     <= '0;
            r_wen_next       <= 1'b0;
            mem_wen_next     <= 1'b0;
            mem_ren_next     <= 1'b0;
            jump_flag_next   <= 1'b0;
            branch_flag_next <= 1'b0;
        end else if (take) begin
            csr_wen_next     <= squash ? '0 : csr_wen;
            r_wen_next       <= r_wen & ~squash;
            mem_wen_next     <= mem_wen & ~squash;
            mem_ren_next     <= mem_ren & ~squash;
            jump_flag_next   <= jump_flag & ~squash;
            branch_flag_next <= branch_flag & ~squash;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_next <= '0;
        end else if (inst_clear) begin
            inst_next <= '0;
        end else if (take) begin
            inst_next <= inst;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_next        <= pc;
            imm_next       <= imm;
            rs1_q          <= rs1_value;
            rs2_value_next <= rs2_value;
            csrs_next      <= csrs;
            rd_next        <= rd;
            funct3_next    <= funct3;
            imm_op_q       <= imm_op;
            alu_op_q       <= alu_op;
            src1_sel_q     <= src1_sel;
            src2_sel_q     <= src2_sel;
            inv_flag_q     <= inv_flag;
        end
    end

    imm_gen imm_gen_i (
        .imm     (imm_next),
        .imm_op  (imm_op_q),
        .imm_ext (imm_ext)
    );

    always_comb begin
        case (src1_sel_q)
            SRC1_RS1: begin
                op_a = rs1_q;
            end
            SRC1_PC: begin
                op_a = pc_next;
            end
            default: begin
                op_a = '0;
            end
        endcase
    end

    always_comb begin
        case (src2_sel_q)
            SRC2_IMM: begin
                op_b = imm_ext;
            end
            SRC2_RS2: begin
                op_b = rs2_value_next;
            end
            SRC2_CSR: begin
                op_b = csrs_next;
            end
            default: begin
                op_b = '0;
            end
        endcase
    end

    alu alu_i (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op_q),
        .result (alu_result)
    );

    // Flipping bit 0 turns EQ, SLT and SLTU into NE, GE and GEU.
    assign ex_result = alu_result ^ {{(`EXU_XLEN-1){1'b0}}, inv_flag_q};

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

`include "exu_consts.svh"

module alu (
    input  logic [`EXU_XLEN-1:0]  a,
    input  logic [`EXU_XLEN-1:0]  b,
    input  exu_pkg::alu_op_t      op,
    output logic [`EXU_XLEN-1:0]  result
);

    import exu_pkg::*;

    logic [`EXU_SHAMT_W-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;
    logic                    equal;

    assign shamt       = b[`EXU_SHAMT_W-1:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;
    assign equal       = a == b;

    // Compares return a single flag in bit 0.
    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                result = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_EQ: begin
                result = {{(`EXU_XLEN-1){1'b0}}, equal};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* verilog/imm_gen.sv */
`timescale 1ns/1ps

`include "exu_consts.svh"

module imm_gen (
    input  exu_pkg::imm_word_t    imm,
    input  exu_pkg::imm_op_t      imm_op,
    output logic [`EXU_XLEN-1:0]  imm_ext
);

    import exu_pkg::*;

    always_comb begin
        case (imm_op)
            IMM_I12: begin
                imm_ext = {{(`EXU_XLEN-12){imm.i.imm12[11]}}, imm.i.imm12};
            end
            IMM_U20: begin
                imm_ext = {imm.uj.imm20, 12'd0};
            end
            // Jump offsets are stored in halfword units.
            IMM_J20: begin
                imm_ext = {{(`EXU_XLEN-21){imm.uj.imm20[19]}}, imm.uj.imm20, 1'b0};
            end
            IMM_SHAMT: begin
                imm_ext = {{(`EXU_XLEN-`EXU_SHAMT_W){1'b0}}, imm.sh.shamt};
            end
            default: begin
                imm_ext = '0;
            end
        endcase
    end

endmodule

/* verilog/exu_pkg.sv */
`include "exu_consts.svh"

package exu_pkg;

    // Immediate formats as delivered by decode.
    typedef enum logic [`EXU_IMM_OP_W-1:0] {
        IMM_I12   = 2'd0,
        IMM_U20   = 2'd1,
        IMM_J20   = 2'd2,
        IMM_SHAMT = 2'd3
    } imm_op_t;

    // The fourth first-operand code is not named and selects zero as well.
    typedef enum logic [`EXU_SRC_SEL_W-1:0] {
        SRC1_RS1  = `EXU_SRC1_RS1,
        SRC1_PC   = `EXU_SRC1_PC,
        SRC1_ZERO = `EXU_SRC1_ZERO
    } src1_sel_t;

    typedef enum logic [`EXU_SRC_SEL_W-1:0] {
        SRC2_IMM  = `EXU_SRC2_IMM,
        SRC2_RS2  = `EXU_SRC2_RS2,
        SRC2_CSR  = `EXU_SRC2_CSR,
        SRC2_ZERO = `EXU_SRC2_ZERO
    } src2_sel_t;

    typedef enum logic [`EXU_ALU_OP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_EQ   = 4'd10
    } alu_op_t;

    typedef struct packed {
        logic [`EXU_XLEN-13:0] pad;
        logic [11:0]           imm12;
    } imm_i_view_t;

    typedef struct packed {
        logic [`EXU_XLEN-21:0] pad;
        logic [19:0]           imm20;
    } imm_uj_view_t;

    typedef struct packed {
        logic [`EXU_XLEN-`EXU_SHAMT_W-1:0] pad;
        logic [`EXU_SHAMT_W-1:0]           shamt;
    } imm_sh_view_t;

    // One immediate word, read through the view that its format code names.
    typedef union packed {
        imm_i_view_t  i;
        imm_uj_view_t uj;
        imm_sh_view_t sh;
    } imm_word_t;

endpackage

/* verilog/exu_consts.svh */
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// Data path and instruction field widths.
`define EXU_XLEN      32
`define EXU_REG_AW    5
`define EXU_SHAMT_W   5
`define EXU_FUNCT3_W  3
`define EXU_CSR_WEN_W 4

// Widths of the select and operation codes that decode hands over.
`define EXU_IMM_OP_W  2
`define EXU_SRC_SEL_W 2
`define EXU_ALU_OP_W  4

// Operand source codes.
`define EXU_SRC1_RS1  2'd0
`define EXU_SRC1_PC   2'd1
`define EXU_SRC1_ZERO 2'd2

`define EXU_SRC2_IMM  2'd0
`define EXU_SRC2_RS2  2'd1
`define EXU_SRC2_CSR  2'd2
`define EXU_SRC2_ZERO 2'd3

`endif
